// File: Makefile
TOP = tb_stereo_capture

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Errors found" sim.log; then \
		echo "simulation FAILED, see sim.log"; \
		exit 1; \
	fi
	@if ! grep -q "No errors" sim.log; then \
		echo "simulation did not complete, see sim.log"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// File: common/stereo_cfg.svh
`ifndef STEREO_CFG_SVH
`define STEREO_CFG_SVH

// fifo depth is 2**this
`define STEREO_FIFO_DEPTH_LOG2 4

// almost_empty is high at or below this fill level
`define STEREO_AEMPTY_LEVEL 2

// level of hsync that clears a camera write side
`define STEREO_HSYNC_ACTIVE 1'b1

`endif

// File: common/stereo_pkg.sv
package stereo_pkg;

    // camera word and per-line pair count widths
    localparam int PIXEL_W    = 16;
    localparam int PAIR_CNT_W = 11;

    // one camera pixel as it comes off the parallel port
    typedef logic [PIXEL_W-1:0] pixel_t;

    // pairs delivered in one line, saturates at all ones
    typedef logic [PAIR_CNT_W-1:0] pair_cnt_t;

endpackage : stereo_pkg

// File: hw/pair_counter.sv
`timescale 1ns/1ns

module pair_counter (
    input  logic                  rclk       ,
    input  logic                  rstn       ,
    input  logic                  pixel_valid,
    input  logic                  line_end   ,
    output stereo_pkg::pair_cnt_t pair_count ,
    output logic                  line_done
);

    localparam stereo_pkg::pair_cnt_t CNT_MAX = '1;

    stereo_pkg::pair_cnt_t cnt;
    stereo_pkg::pair_cnt_t cnt_next;

    // a pair can land in the same cycle as line_end
    always_comb begin
        cnt_next = cnt;
        if (pixel_valid && (cnt != CNT_MAX)) begin
            cnt_next = cnt + 1'b1;
        end
    end

    always_ff @(posedge rclk or negedge rstn) begin
        if (~rstn) begin
            cnt        <= '0;
            pair_count <= '0;
            line_done  <= 1'b0;
        end else begin
            line_done <= line_end;
            if (line_end) begin
                pair_count <= cnt_next;   // held until the next line closes
                cnt        <= '0;
            end else begin
                cnt <= cnt_next;
            end
        end
    end

endmodule : pair_counter

// File: hw/stereo_capture_top.sv
`timescale 1ns/1ns

module stereo_capture_top (
    input  logic                  rclk       ,
    input  logic                  rstn       ,

    input  logic                  inited_1   ,
    input  logic                  hsync_1    ,
    input  logic                  pclk_1     ,
    input  logic                  href_1     ,
    input  stereo_pkg::pixel_t    data_1     ,

    input  logic                  inited_2   ,
    input  logic                  hsync_2    ,
    input  logic                  pclk_2     ,
    input  logic                  href_2     ,
    input  stereo_pkg::pixel_t    data_2     ,

    output stereo_pkg::pixel_t    pixel_1    ,
    output stereo_pkg::pixel_t    pixel_2    ,
    output logic                  pixel_valid,
    output logic                  error      ,
    output stereo_pkg::pair_cnt_t pair_count ,
    output logic                  line_done
);

    logic line_end;

    pixel_combine u_pixel_combine (
        .rclk       (rclk       ),
        .rstn       (rstn       ),
        .pixel_1    (pixel_1    ),
        .pixel_2    (pixel_2    ),
        .pixel_valid(pixel_valid),
        .line_end   (line_end   ),
        .error      (error      ),
        .inited_1   (inited_1   ),
        .hsync_1    (hsync_1    ),
        .pclk_1     (pclk_1     ),
        .href_1     (href_1     ),
        .data_1     (data_1     ),
        .inited_2   (inited_2   ),
        .hsync_2    (hsync_2    ),
        .pclk_2     (pclk_2     ),
        .href_2     (href_2     ),
        .data_2     (data_2     )
    );

    // pairs per line, closed by camera 1
    pair_counter u_pair_counter (
        .rclk       (rclk       ),
        .rstn       (rstn       ),
        .pixel_valid(pixel_valid),
        .line_end   (line_end   ),
        .pair_count (pair_count ),
        .line_done  (line_done  )
    );

endmodule : stereo_capture_top

// File: pixel_combine/async_fifo.sv
`timescale 1ns/1ns
`include "stereo_cfg.svh"

module async_fifo (
    // write side
    input  stereo_pkg::pixel_t wr_data     ,
    input  logic               wr_en       ,
    input  logic               wr_clk      ,
    input  logic               wr_rst      ,
    output logic               wr_full     ,
    output logic               almost_full ,

    // read side
    output stereo_pkg::pixel_t rd_data     ,
    input  logic               rd_en       ,
    input  logic               rd_clk      ,
    input  logic               rd_rst      ,
    output logic               rd_empty    ,
    output logic               almost_empty
);

    localparam int AW    = `STEREO_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << AW;

    localparam logic [AW:0] AEMPTY_LEVEL = (AW+1)'(`STEREO_AEMPTY_LEVEL);
    localparam logic [AW:0] AFULL_LEVEL  = (AW+1)'(DEPTH - `STEREO_AEMPTY_LEVEL);

    stereo_pkg::pixel_t mem [DEPTH];

    logic [AW:0] wbin, wbin_next;
    logic [AW:0] wgray, wgray_next;
    logic [AW:0] rbin, rbin_next;
    logic [AW:0] rgray, rgray_next;

    logic [AW:0] wq1_rgray, wq2_rgray;   // read pointer seen by writer
    logic [AW:0] rq1_wgray, rq2_wgray;   // write pointer seen by reader

    logic [AW:0] wr_rbin, rd_wbin;
    logic [AW:0] wr_level, rd_level;
    logic        wr_inc, rd_inc;

    function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
        logic [AW:0] b;
        b[AW] = g[AW];
        for (int i = AW - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write domain
    assign wr_inc     = wr_en & ~wr_full;   // words arriving while full are dropped
    assign wbin_next  = wbin + (AW+1)'(wr_inc);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    always_ff @(posedge wr_clk) begin
        if (wr_inc) begin
            mem[wbin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            wq1_rgray <= '0;
            wq2_rgray <= '0;
        end else begin
            wq1_rgray <= rgray;
            wq2_rgray <= wq1_rgray;
        end
    end

    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            wbin    <= '0;
            wgray   <= '0;
            wr_full <= 1'b0;
        end else begin
            wbin    <= wbin_next;
            wgray   <= wgray_next;
            // full when the two msbs differ and the rest match
            wr_full <= (wgray_next == {~wq2_rgray[AW:AW-1], wq2_rgray[AW-2:0]});
        end
    end

    assign wr_rbin     = gray2bin(wq2_rgray);
    assign wr_level    = wbin - wr_rbin;
    assign almost_full = (wr_level >= AFULL_LEVEL);

    // read domain
    assign rd_empty   = (rgray == rq2_wgray);
    assign rd_inc     = rd_en & ~rd_empty;
    assign rbin_next  = rbin + (AW+1)'(rd_inc);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            rq1_wgray <= '0;
            rq2_wgray <= '0;
        end else begin
            rq1_wgray <= wgray;
            rq2_wgray <= rq1_wgray;
        end
    end

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            rbin  <= '0;
            rgray <= '0;
        end else begin
            rbin  <= rbin_next;
            rgray <= rgray_next;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_inc) begin
            rd_data <= mem[rbin[AW-1:0]];   // valid from the edge after the pop
        end
    end

    // fill level as the reader sees it, may lag the writer
    assign rd_wbin      = gray2bin(rq2_wgray);
    assign rd_level     = rd_wbin - rbin;
    assign almost_empty = (rd_level <= AEMPTY_LEVEL);

endmodule : async_fifo

// File: pixel_combine/pixel_combine.sv
`timescale 1ns/1ns
`include "stereo_cfg.svh"

module pixel_combine (
    input  logic               rclk       ,
    input  logic               rstn       ,
    output stereo_pkg::pixel_t pixel_1    ,
    output stereo_pkg::pixel_t pixel_2    ,
    output logic               pixel_valid,
    output logic               line_end   ,
    output logic               error      ,

    input  logic               inited_1   ,
    input  logic               hsync_1    ,
    input  logic               pclk_1     ,
    input  logic               href_1     ,
    input  stereo_pkg::pixel_t data_1     ,

    input  logic               inited_2   ,
    input  logic               hsync_2    ,
    input  logic               pclk_2     ,
    input  logic               href_2     ,
    input  stereo_pkg::pixel_t data_2
);

    logic rst_1, rst_2;         // write side, async
    logic rst_1_d, rst_2_d;     // read side, one rclk later
    logic rst_1_q;              // for the line_end edge
    logic full_1, empty_1, aempty_1;
    logic full_2, empty_2, aempty_2;
    logic [1:0] full_1_sync, full_2_sync;
    logic re;
    logic pop;

    assign rst_1 = ~inited_1 || (hsync_1 == `STEREO_HSYNC_ACTIVE);
    assign rst_2 = ~inited_2 || (hsync_2 == `STEREO_HSYNC_ACTIVE);

    always_ff @(posedge rclk or negedge rstn) begin
        if (~rstn) begin
            rst_1_d <= 1'b1;
            rst_2_d <= 1'b1;
            rst_1_q <= 1'b1;   // no line_end straight out of reset
        end else begin
            rst_1_d <= rst_1;
            rst_2_d <= rst_2;
            rst_1_q <= rst_1_d;
        end
    end

    assign line_end = rst_1_d & ~rst_1_q;

    async_fifo u_sync_1 (
        .wr_data     (data_1  ),
        .wr_en       (href_1  ),
        .wr_clk      (pclk_1  ),
        .wr_rst      (rst_1   ),
        .wr_full     (full_1  ),
        .almost_full (        ),
        .rd_data     (pixel_1 ),
        .rd_en       (pop     ),
        .rd_clk      (rclk    ),
        .rd_rst      (rst_1_d ),
        .rd_empty    (empty_1 ),
        .almost_empty(aempty_1)
    );

    async_fifo u_sync_2 (
        .wr_data     (data_2  ),
        .wr_en       (href_2  ),
        .wr_clk      (pclk_2  ),
        .wr_rst      (rst_2   ),
        .wr_full     (full_2  ),
        .almost_full (        ),
        .rd_data     (pixel_2 ),
        .rd_en       (pop     ),
        .rd_clk      (rclk    ),
        .rd_rst      (rst_2_d ),
        .rd_empty    (empty_2 ),
        .almost_empty(aempty_2)
    );

    // both sides pop together so the pair stays aligned
    assign pop = re && ~empty_1 && ~empty_2;

    always_ff @(posedge rclk or negedge rstn) begin
        if (~rstn) begin
            re          <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            if (empty_1 || empty_2) begin
                re <= 1'b0;
            end else if (~aempty_1 && ~aempty_2) begin
                re <= 1'b1;
            end
            pixel_valid <= pop;
        end
    end

    // full flags come from the pixel clocks
    always_ff @(posedge rclk or negedge rstn) begin
        if (~rstn) begin
            full_1_sync <= '0;
            full_2_sync <= '0;
            error       <= 1'b0;
        end else begin
            full_1_sync <= {full_1_sync[0], full_1};
            full_2_sync <= {full_2_sync[0], full_2};
            if (full_1_sync[1] || full_2_sync[1]) begin
                error <= 1'b1;   // sticky until rstn
            end
        end
    end

endmodule : pixel_combine

// File: project.f
+incdir+common
common/stereo_pkg.sv
pixel_combine/async_fifo.sv
pixel_combine/pixel_combine.sv
hw/pair_counter.sv
hw/stereo_capture_top.sv
tb/tb_stereo_capture.sv

// File: tb/stereo_vectors.txt
# test  pixels  start_1  start_2  overflow   (starts in hex)
# overflow 1: camera 1 writes alone until its fifo fills, camera 2 stays idle
1   8   0000  1000  0
2   1   0010  0020  0
3   2   0100  0200  0
4   3   0300  0400  0
5   12  1234  4321  0
6   16  fff8  7ff0  0
7   24  2000  3000  0
8   5   abcd  0001  0
9   20  5555  aaaa  0
10  9   0f00  f0f0  0
11  17  ffff  0000  0
12  20  0040  0000  1
13  10  4000  8000  0
14  24  7777  8888  0
15  4   0abc  0def  0
16  13  c000  c100  0
17  22  0000  ffff  0
18  7   1111  2222  0

// File: tb/tb_stereo_capture.sv
`timescale 1ns/1ns
`include "stereo_cfg.svh"

module tb_stereo_capture;

    localparam int TIMEOUT = 2000;   // cycles allowed per wait
    localparam int QUIET   = 16;     // idle rclk cycles before a line is closed
    localparam int SKEW    = 4;      // pixels one camera may run ahead of the other

    logic rclk   = 1'b0;
    logic pclk_1 = 1'b0;
    logic pclk_2 = 1'b0;
    logic rstn;
    logic inited_1, hsync_1, href_1;
    logic inited_2, hsync_2, href_2;
    stereo_pkg::pixel_t    data_1, data_2;
    stereo_pkg::pixel_t    pixel_1, pixel_2;
    logic                  pixel_valid, error, line_done;
    stereo_pkg::pair_cnt_t pair_count;

    logic [31:0]        lfsr_1, lfsr_2;
    int                 sent_1, sent_2;
    int                 pairs_seen;
    stereo_pkg::pixel_t base_1, base_2;   // start values of the open line
    int                 errors, checks;
    bit                 hung, err_sticky;

    always #10 rclk = ~rclk;
    always #13 pclk_1 = ~pclk_1;
    always #17 pclk_2 = ~pclk_2;

    stereo_capture_top i_stereo_capture_top (.*);

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic compare_pixel(input string name, input stereo_pkg::pixel_t got,
                                 input stereo_pkg::pixel_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input stereo_pkg::pair_cnt_t got,
                                 input stereo_pkg::pair_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s, gave up after %0d cycles", what, TIMEOUT);
        errors++;
        hung = 1'b1;
    endtask

    // k-th pair of a line carries start + k from both cameras
    always @(negedge rclk) begin
        if (pixel_valid === 1'b1) begin
            compare_pixel("pixel_1", pixel_1, base_1 + stereo_pkg::pixel_t'(pairs_seen));
            compare_pixel("pixel_2", pixel_2, base_2 + stereo_pkg::pixel_t'(pairs_seen));
            pairs_seen++;
        end
    end

    task automatic own_edge(input int cam);
        if (cam == 1) begin
            @(posedge pclk_1);
        end else begin
            @(posedge pclk_2);
        end
    endtask

    task automatic drive_camera(input int cam, input logic href, input stereo_pkg::pixel_t data);
        if (cam == 1) begin
            href_1 <= href;
            data_1 <= data;
        end else begin
            href_2 <= href;
            data_2 <= data;
        end
    endtask

    task automatic camera_write(input int cam, input int len, input stereo_pkg::pixel_t start,
                                input bit paced);
        int n;
        int cycles;
        bit gap;
        bit ahead;
        n = 0;
        cycles = 0;
        while (n < len && !hung) begin
            own_edge(cam);
            if (cam == 1) begin
                lfsr_1 = lfsr_next(lfsr_1);
                gap    = ~lfsr_1[0];
                ahead  = paced && (n - sent_2 >= SKEW);
            end else begin
                lfsr_2 = lfsr_next(lfsr_2);
                gap    = ~lfsr_2[0];
                ahead  = paced && (n - sent_1 >= SKEW);
            end
            if (gap || ahead) begin
                drive_camera(cam, 1'b0, '0);
            end else begin
                drive_camera(cam, 1'b1, start + stereo_pkg::pixel_t'(n));
                n++;
            end
            if (cam == 1) begin
                sent_1 = n;
            end else begin
                sent_2 = n;
            end
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_timeout($sformatf("camera %0d could not send its line", cam));
            end
        end
        own_edge(cam);
        drive_camera(cam, 1'b0, '0);   // href low after the last pixel
    endtask

    task automatic pulse_hsync(input int cam);
        own_edge(cam);
        if (cam == 1) begin
            hsync_1 <= `STEREO_HSYNC_ACTIVE;
        end else begin
            hsync_2 <= `STEREO_HSYNC_ACTIVE;
        end
        repeat (2) own_edge(cam);
        if (cam == 1) begin
            hsync_1 <= ~`STEREO_HSYNC_ACTIVE;
        end else begin
            hsync_2 <= ~`STEREO_HSYNC_ACTIVE;
        end
    endtask

    // reader has drained what it is going to take
    task automatic wait_quiet();
        int idle;
        int cycles;
        idle = 0;
        cycles = 0;
        while (idle < QUIET && !hung) begin
            @(negedge rclk);
            idle = (pixel_valid === 1'b1) ? 0 : idle + 1;
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_timeout("pixel pairs kept coming after both cameras stopped");
            end
        end
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        while (line_done !== 1'b1 && !hung) begin
            @(negedge rclk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_timeout("line_done never pulsed after hsync");
            end
        end
    endtask

    task automatic wait_error_high();
        int cycles;
        cycles = 0;
        while (error !== 1'b1 && !hung) begin
            @(negedge rclk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_timeout("error never rose while the fifo overflowed");
            end
        end
    endtask

    task automatic check_idle();
        compare_flag("error", error, 1'b0);
        compare_flag("pixel_valid", pixel_valid, 1'b0);
        compare_flag("line_done", line_done, 1'b0);
        compare_count("pair_count", pair_count, '0);
    endtask

    task automatic run_line(input int num, input int len, input stereo_pkg::pixel_t s1,
                            input stereo_pkg::pixel_t s2, input bit ovf);
        int err_before;
        int exp_pairs;
        err_before = errors;
        pairs_seen = 0;
        base_1 = s1;
        base_2 = s2;
        sent_1 = 0;
        sent_2 = 0;
        if (ovf) begin
            camera_write(1, len, s1, 1'b0);   // camera 2 idle, nothing can pop
            wait_error_high();
            err_sticky = 1'b1;
        end else begin
            fork
                camera_write(1, len, s1, 1'b1);
                camera_write(2, len, s2, 1'b1);
            join
            wait_quiet();
        end
        fork
            pulse_hsync(1);
            pulse_hsync(2);
            wait_line_done();   // line_done can come while hsync_2 is still active
        join
        if (!hung) begin
            exp_pairs = ovf ? 0 : pairs_seen;
            compare_count("pair_count", pair_count, stereo_pkg::pair_cnt_t'(exp_pairs));
            compare_flag("error", error, err_sticky);
            if (!ovf && (len - pairs_seen > `STEREO_AEMPTY_LEVEL || pairs_seen > len)) begin
                errors++;
                $display("line %0d closed with %0d of %0d pixels paired, too many left unread",
                         num, pairs_seen, len);
            end
        end
        $display("test %0d: %0d pixels, %0d pairs, %s", num, len, pairs_seen,
                 (errors == err_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int    fd;
        int    num, len, ovf, got, tests;
        string line;
        stereo_pkg::pixel_t s1, s2;
        rstn     = 1'b0;
        inited_1 = 1'b0;
        inited_2 = 1'b0;
        hsync_1  = ~`STEREO_HSYNC_ACTIVE;
        hsync_2  = ~`STEREO_HSYNC_ACTIVE;
        href_1   = 1'b0;
        href_2   = 1'b0;
        data_1   = '0;
        data_2   = '0;
        lfsr_1   = 32'd65917;
        lfsr_2   = 32'd65917;
        repeat (16) lfsr_2 = lfsr_next(lfsr_2);   // camera 2 uses a later stretch
        errors = 0;
        checks = 0;
        tests = 0;
        hung = 1'b0;
        err_sticky = 1'b0;
        pairs_seen = 0;
        base_1 = '0;
        base_2 = '0;

        repeat (2) @(posedge rclk);
        rstn <= 1'b1;
        @(negedge rclk);
        check_idle();
        fork
            begin
                @(posedge pclk_1);
                inited_1 <= 1'b1;
            end
            begin
                @(posedge pclk_2);
                inited_2 <= 1'b1;
            end
        join

        fd = $fopen("tb/stereo_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/stereo_vectors.txt");
            errors++;
        end else begin
            while (!hung && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%d %d %h %h %d", num, len, s1, s2, ovf);
                    if (got == 5) begin
                        run_line(num, len, s1, s2, ovf != 0);
                        tests++;
                    end else begin
                        $display("unreadable vector line: %s", line);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end

        // sticky error only clears with rstn
        if (!hung) begin
            @(posedge rclk);
            rstn <= 1'b0;
            repeat (2) @(posedge rclk);
            rstn <= 1'b1;
            err_sticky = 1'b0;
            @(negedge rclk);
            check_idle();
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_stereo_capture
